/* common/csr_pkg.sv */
//////////////////////////////
// Machine-mode CSR unit, RV32 only. XLEN is fixed at 32
// misa fixed at RV32I, mtip/msip are not implemented
//////////////////////////////

package csr_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;
    localparam int ZIMM_W     = 5;  // Immediate forms reuse the rs1 field

    // Field positions in the instruction word
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int CSR_LSB    = 20;

    //////////////////////////////
    // Fixed values and masks
    //////////////////////////////

    // MXL=1 (32-bit) in 31:30, I extension in bit 8
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

    // WPRI 30:23, 10:9, 6 and 2 read as zero
    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h807F_F9BB;

    localparam int MEIP_BIT = 11;   // mie/mip external irq
    localparam int MIE_BIT  = 3;    // mstatus global enable

    //////////////////////////////
    // Enums
    //////////////////////////////

    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_MHARTID  = 12'hF14     // Read only
    } csr_addr_e;

    // funct3 of the Zicsr instructions
    typedef enum logic [2:0] {
        OP_CSRRW  = 3'b001,
        OP_CSRRS  = 3'b010,
        OP_CSRRC  = 3'b011,
        OP_CSRRWI = 3'b101,
        OP_CSRRSI = 3'b110,
        OP_CSRRCI = 3'b111
    } csr_op_e;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE
    } exec_state_e;

    //////////////////////////////
    // Structs
    //////////////////////////////

    typedef struct packed {
        csr_op_e                op;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;    // rs1 index or zimm
        logic [CSR_ADDR_W-1:0]  csr;    // Raw, may be unknown
    } csr_inst_t;

    typedef struct packed {
        logic                   en;
        logic [CSR_ADDR_W-1:0]  addr;
        logic [XLEN-1:0]        data;
    } csr_wr_t;

    typedef struct packed {
        logic                   en;
        logic [XLEN-1:0]        val;
    } trap_field_t;

    typedef struct packed {
        trap_field_t            mepc;
        trap_field_t            mstatus;
        trap_field_t            mcause;
        trap_field_t            mtval;
    } trap_upd_t;

    typedef struct packed {
        logic [XLEN-1:0]        mtvec;
        logic [XLEN-1:0]        mepc;
        logic [XLEN-1:0]        mstatus;
        logic                   meip;
        logic                   mtip;   // Always zero
        logic                   msip;   // Always zero
    } csr_sb_t;

endpackage

/* csr/csr_exec.sv */
//////////////////////////////
// One instruction in flight, ready low for three cycles after acceptance
// No back-pressure on the rd write pulse
//////////////////////////////

`timescale 1ns/100ps

module csr_exec
    import csr_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  valid,
    output logic                  ready,
    input  csr_inst_t             inst,
    input  logic [XLEN-1:0]       rs1_val,
    output logic                  rd_en,
    output logic [CSR_ADDR_W-1:0] rd_addr,
    input  logic [XLEN-1:0]       rd_data,
    output csr_wr_t               csr_wr,
    output logic                  rd_wr_en,
    output logic [REG_ADDR_W-1:0] rd_wr_addr,
    output logic [XLEN-1:0]       rd_wr_val
);

    exec_state_e      state;
    csr_inst_t        inst_r;       // Held until the next acceptance
    logic [XLEN-1:0]  rs1_val_r;
    logic [XLEN-1:0]  zimm_ext;
    logic [XLEN-1:0]  newval;
    logic             wr_req;       // Op writes the CSR
    logic             wr_en_q;
    logic [XLEN-1:0]  wr_data_q;
    logic             accept;

    assign accept = valid && ready;

    // Old value fetch goes out on the acceptance edge
    assign rd_en   = accept;
    assign rd_addr = inst.csr;

    assign zimm_ext = {{(XLEN-ZIMM_W){1'b0}}, inst_r.rs1};

    //////////////////////////////
    // New value
    //////////////////////////////

    // rd_data holds the old value during COMPUTE
    always_comb begin
        newval = rd_data;
        wr_req = 1'b0;
        case (inst_r.op)
            OP_CSRRW: begin
                newval = rs1_val_r;
                wr_req = 1'b1;              // Always writes
            end
            OP_CSRRS: begin
                newval = rd_data | rs1_val_r;
                wr_req = |inst_r.rs1;       // x0 means read only
            end
            OP_CSRRC: begin
                newval = rd_data & ~rs1_val_r;
                wr_req = |inst_r.rs1;
            end
            OP_CSRRWI: begin
                newval = zimm_ext;
                wr_req = 1'b1;
            end
            OP_CSRRSI: begin
                newval = rd_data | zimm_ext;
                wr_req = |inst_r.rs1;       // zimm of zero
            end
            OP_CSRRCI: begin
                newval = rd_data & ~zimm_ext;
                wr_req = |inst_r.rs1;
            end
            default: begin
                wr_req = 1'b0;              // Not a CSR op, return old value only
            end
        endcase
    end

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            ready    <= 1'b0;
            rd_wr_en <= 1'b0;
            wr_en_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    ready <= 1'b1;      // First edge after reset raises it
                    if (accept) begin
                        ready <= 1'b0;
                        state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    rd_wr_en <= 1'b1;   // One-cycle pulses
                    wr_en_q  <= wr_req;
                    state    <= STORE;
                end
                STORE: begin
                    rd_wr_en <= 1'b0;
                    wr_en_q  <= 1'b0;
                    // Extra cycle so the next read sees the update
                    if (!rd_wr_en) begin
                        ready <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge aclk) begin
        if (accept) begin
            inst_r    <= inst;
            rs1_val_r <= rs1_val;
        end
        if (state == COMPUTE) begin
            rd_wr_val <= rd_data;   // Old value back to rd
            wr_data_q <= newval;
        end
    end

    assign rd_wr_addr = inst_r.rd;
    assign csr_wr     = '{en: wr_en_q, addr: inst_r.csr, data: wr_data_q};

    //////////////////////////////
    // Assertions
    //////////////////////////////

    a_rd_wr_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr_en |=> !rd_wr_en);

    a_busy_on_wb: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr_en |-> !ready);

endmodule

/* csr/csr_regfile.sv */
//////////////////////////////
// Unknown addresses read zero and drop writes
// Trap-side update beats an instruction write to the same CSR
//////////////////////////////

`timescale 1ns/100ps

module csr_regfile
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] MHART_ID = '0
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  rd_en,
    input  logic [CSR_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       rd_data,
    input  csr_wr_t               csr_wr,
    input  trap_upd_t             trap_upd,
    input  logic                  eirq,
    output csr_sb_t               csr_sb
);

    // Writable CSRs
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mip;

    logic [1:0]      eirq_sync;     // Two-flop synchronizer
    logic            meip_set;

    // Instruction write hits a given CSR
    function automatic logic hit(csr_wr_t w, csr_addr_e a);
        return w.en && (w.addr == a);
    endfunction

    //////////////////////////////
    // External interrupt
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            eirq_sync <= 2'b00;
        end else begin
            eirq_sync <= {eirq_sync[0], eirq};
        end
    end

    // Both enables must be on when the synced level arrives
    assign meip_set = eirq_sync[1] && mstatus[MIE_BIT] && mie[MEIP_BIT];

    //////////////////////////////
    // CSR storage
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mip      <= '0;
        end else begin
            // Trap side first, then the instruction write
            if (trap_upd.mstatus.en) begin
                mstatus <= trap_upd.mstatus.val & MSTATUS_WMASK;
            end else if (hit(csr_wr, CSR_MSTATUS)) begin
                mstatus <= csr_wr.data & MSTATUS_WMASK;
            end

            if (trap_upd.mepc.en) begin
                mepc <= {trap_upd.mepc.val[XLEN-1:2], 2'b00};   // IALIGN=32
            end else if (hit(csr_wr, CSR_MEPC)) begin
                mepc <= {csr_wr.data[XLEN-1:2], 2'b00};
            end

            if (trap_upd.mcause.en) begin
                mcause <= trap_upd.mcause.val;
            end else if (hit(csr_wr, CSR_MCAUSE)) begin
                mcause <= csr_wr.data;
            end

            if (trap_upd.mtval.en) begin
                mtval <= trap_upd.mtval.val;
            end else if (hit(csr_wr, CSR_MTVAL)) begin
                mtval <= csr_wr.data;
            end

            // Instruction-only registers
            if (hit(csr_wr, CSR_MIE)) begin
                mie <= csr_wr.data;
            end
            if (hit(csr_wr, CSR_MTVEC)) begin
                mtvec <= csr_wr.data;
            end
            if (hit(csr_wr, CSR_MSCRATCH)) begin
                mscratch <= csr_wr.data;
            end

            if (hit(csr_wr, CSR_MIP)) begin
                mip <= csr_wr.data;
            end
            if (meip_set) begin
                mip[MEIP_BIT] <= 1'b1;  // Sticky until software writes mip
            end
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Registered, valid the cycle after rd_en
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            case (rd_addr)
                CSR_MSTATUS:  rd_data <= mstatus;
                CSR_MISA:     rd_data <= MISA_VALUE;
                CSR_MIE:      rd_data <= mie;
                CSR_MTVEC:    rd_data <= mtvec;
                CSR_MSCRATCH: rd_data <= mscratch;
                CSR_MEPC:     rd_data <= mepc;
                CSR_MCAUSE:   rd_data <= mcause;
                CSR_MTVAL:    rd_data <= mtval;
                CSR_MIP:      rd_data <= mip;
                CSR_MHARTID:  rd_data <= MHART_ID;
                default:      rd_data <= '0;    // Unimplemented
            endcase
        end
    end

    // Shared bus, straight from the registers
    assign csr_sb = '{
        mtvec:   mtvec,
        mepc:    mepc,
        mstatus: mstatus,
        meip:    mip[MEIP_BIT],
        mtip:    1'b0,
        msip:    1'b0
    };

    a_mepc_align: assert property (@(posedge aclk) disable iff (!aresetn)
        mepc[1:0] == 2'b00);

endmodule

/* logic/csr_unit.sv */
//////////////////////////////
// Opcode is not checked, core sends only SYSTEM/Zicsr words
//////////////////////////////

`timescale 1ns/100ps

module csr_unit
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] MHART_ID = '0
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  eirq,
    input  logic                  valid,
    output logic                  ready,
    input  logic [INST_W-1:0]     instbus,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [XLEN-1:0]       rs1_val,
    output logic                  rd_wr_en,
    output logic [REG_ADDR_W-1:0] rd_wr_addr,
    output logic [XLEN-1:0]       rd_wr_val,
    input  trap_upd_t             trap_upd,
    output csr_sb_t               csr_sb
);

    csr_inst_t             inst;
    logic                  rd_en;
    logic [CSR_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_data;
    csr_wr_t               csr_wr;

    // Instruction fields
    assign inst.op  = csr_op_e'(instbus[FUNCT3_LSB +: 3]);
    assign inst.rd  = instbus[RD_LSB +: REG_ADDR_W];
    assign inst.rs1 = instbus[RS1_LSB +: REG_ADDR_W];
    assign inst.csr = instbus[CSR_LSB +: CSR_ADDR_W];

    assign rs1_addr = inst.rs1;     // Combinational lookup by the core

    csr_exec u_exec (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .ready      (ready),
        .inst       (inst),
        .rs1_val    (rs1_val),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .csr_wr     (csr_wr),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val)
    );

    csr_regfile #(.MHART_ID(MHART_ID)) u_regfile (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .csr_wr   (csr_wr),
        .trap_upd (trap_upd),
        .eirq     (eirq),
        .csr_sb   (csr_sb)
    );

endmodule

/* dv/csr_checker.sv */
//////////////////////////////
// Model steps on the rising edge, DUT outputs compared on the falling edge
//////////////////////////////

`timescale 1ns/100ps

module csr_checker
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] MHART_ID = '0
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  valid,
    input  logic                  ready,
    input  logic [INST_W-1:0]     instbus,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [XLEN-1:0]       rs1_val,
    input  logic                  eirq,
    input  trap_upd_t             trap_upd,
    input  logic                  rd_wr_en,
    input  logic [REG_ADDR_W-1:0] rd_wr_addr,
    input  logic [XLEN-1:0]       rd_wr_val,
    input  csr_sb_t               csr_sb,
    output int                    errors
);

    logic [XLEN-1:0]       m_mstatus;
    logic [XLEN-1:0]       m_mie;
    logic [XLEN-1:0]       m_mtvec;
    logic [XLEN-1:0]       m_mscratch;
    logic [XLEN-1:0]       m_mepc;
    logic [XLEN-1:0]       m_mcause;
    logic [XLEN-1:0]       m_mtval;
    logic [XLEN-1:0]       m_mip;
    logic [1:0]            m_sync;      // eirq two-stage sync
    int                    phase;       // 0 idle, 1 to 3 after acceptance
    logic                  exp_ready;
    logic [REG_ADDR_W-1:0] p_rd;        // Instruction in flight
    logic [CSR_ADDR_W-1:0] p_csr;
    logic [XLEN-1:0]       p_old;
    logic [XLEN-1:0]       p_new;
    logic                  p_wr;
    int                    checks;
    int                    last_errors;

    initial begin
        errors      = 0;
        checks      = 0;
        last_errors = 0;
    end

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADDR_W-1:0] a);
        case (a)
            CSR_MSTATUS:  return m_mstatus;
            CSR_MISA:     return MISA_VALUE;
            CSR_MIE:      return m_mie;
            CSR_MTVEC:    return m_mtvec;
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MTVAL:    return m_mtval;
            CSR_MIP:      return m_mip;
            CSR_MHARTID:  return MHART_ID;
            default:      return '0;        // Unknown address
        endcase
    endfunction

    // WARL rules applied on every write path
    task automatic model_write(input logic [CSR_ADDR_W-1:0] a, input logic [XLEN-1:0] d);
        case (a)
            CSR_MSTATUS:  m_mstatus  = d & MSTATUS_WMASK;
            CSR_MIE:      m_mie      = d;
            CSR_MTVEC:    m_mtvec    = d;
            CSR_MSCRATCH: m_mscratch = d;
            CSR_MEPC:     m_mepc     = {d[XLEN-1:2], 2'b00};
            CSR_MCAUSE:   m_mcause   = d;
            CSR_MTVAL:    m_mtval    = d;
            CSR_MIP:      m_mip      = d;
            default:      ;                 // misa, mhartid, unknown
        endcase
    endtask

    task automatic compare(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("%-14s done, %0d mismatches", name, errors - last_errors);
        last_errors = errors;
    endtask

    task automatic summary();
        $display("Totals: %0d checks, %0d mismatches", checks, errors);
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    always @(posedge aclk or negedge aresetn) begin : model
        logic                  meip_set;
        logic                  do_write;
        csr_op_e               op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [XLEN-1:0]       zimm;
        if (!aresetn) begin
            m_mstatus  = '0;
            m_mie      = '0;
            m_mtvec    = '0;
            m_mscratch = '0;
            m_mepc     = '0;
            m_mcause   = '0;
            m_mtval    = '0;
            m_mip      = '0;
            m_sync     = '0;
            phase      = 0;
            exp_ready  = 1'b0;
        end else begin
            // Enables as they stand before this edge
            meip_set = m_sync[1] && m_mstatus[MIE_BIT] && m_mie[MEIP_BIT];
            m_sync   = {m_sync[0], eirq};
            do_write = 1'b0;
            case (phase)
                0: begin
                    if (valid && exp_ready) begin
                        op    = csr_op_e'(instbus[FUNCT3_LSB +: 3]);
                        rs1   = instbus[RS1_LSB +: REG_ADDR_W];
                        zimm  = rs1;                            // Zero-extended
                        p_rd  = instbus[RD_LSB +: REG_ADDR_W];
                        p_csr = instbus[CSR_LSB +: CSR_ADDR_W];
                        p_old = model_read(p_csr);              // Old value before any update
                        case (op)
                            OP_CSRRW:  p_new = rs1_val;
                            OP_CSRRS:  p_new = p_old | rs1_val;
                            OP_CSRRC:  p_new = p_old & ~rs1_val;
                            OP_CSRRWI: p_new = zimm;
                            OP_CSRRSI: p_new = p_old | zimm;
                            default:   p_new = p_old & ~zimm;
                        endcase
                        p_wr      = (op == OP_CSRRW) || (op == OP_CSRRWI) || (rs1 != '0);
                        phase     = 1;
                        exp_ready = 1'b0;
                    end else begin
                        exp_ready = 1'b1;
                    end
                end
                1: phase = 2;
                2: begin
                    do_write = p_wr;        // CSR updates on this edge
                    phase    = 3;
                end
                default: begin
                    phase     = 0;
                    exp_ready = 1'b1;
                end
            endcase
            if (do_write) begin
                model_write(p_csr, p_new);
            end
            // Trap side last so it wins
            if (trap_upd.mepc.en)    model_write(CSR_MEPC, trap_upd.mepc.val);
            if (trap_upd.mstatus.en) model_write(CSR_MSTATUS, trap_upd.mstatus.val);
            if (trap_upd.mcause.en)  model_write(CSR_MCAUSE, trap_upd.mcause.val);
            if (trap_upd.mtval.en)   model_write(CSR_MTVAL, trap_upd.mtval.val);
            if (meip_set) begin
                m_mip[MEIP_BIT] = 1'b1;     // Sticky
            end
        end
    end

    //////////////////////////////
    // Comparison
    //////////////////////////////

    always @(negedge aclk) begin
        compare("ready", exp_ready, ready);
        compare("rd_wr_en", phase == 2, rd_wr_en);
        if (phase == 2) begin
            compare("rd_wr_addr", p_rd, rd_wr_addr);
            compare("rd_wr_val", p_old, rd_wr_val);
        end
        if (valid) begin
            compare("rs1_addr", instbus[19:15], rs1_addr);     // RISC-V rs1 field
        end
        compare("csr_sb.mtvec", m_mtvec, csr_sb.mtvec);
        compare("csr_sb.mepc", m_mepc, csr_sb.mepc);
        compare("csr_sb.mstatus", m_mstatus, csr_sb.mstatus);
        compare("csr_sb.meip", m_mip[MEIP_BIT], csr_sb.meip);
        compare("csr_sb.mtip", '0, csr_sb.mtip);
        compare("csr_sb.msip", '0, csr_sb.msip);
    end

endmodule

/* dv/tb_csr_unit.sv */
//////////////////////////////
// Directed tests, then random traffic from seed 1
// Trap pulses only start after an acceptance
//////////////////////////////

`timescale 1ns/100ps

module tb_csr_unit
    import csr_pkg::*;
();

    localparam int              PERIOD   = 100;
    localparam int              DRV_DLY  = 10;      // After the rising edge
    localparam int              RST_CYC  = 16;
    localparam int              N_RAND   = 300;
    localparam int              N_DIRECT = 64;      // Upper bound, directed part
    localparam int              N_INST   = N_RAND + N_DIRECT;
    localparam logic [XLEN-1:0] HART_ID  = 32'h0000_0003;

    logic                  aclk;
    logic                  aresetn;
    logic                  eirq;
    logic                  valid;
    logic                  ready;
    logic [INST_W-1:0]     instbus;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       rs1_val;
    logic                  rd_wr_en;
    logic [REG_ADDR_W-1:0] rd_wr_addr;
    logic [XLEN-1:0]       rd_wr_val;
    trap_upd_t             trap_upd;
    csr_sb_t               csr_sb;
    int                    errors;
    int                    seed = 1;

    csr_addr_e addr_list [10] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                                  CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MHARTID};
    csr_op_e   op_list [6]    = '{OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};

    always #(PERIOD/2) aclk = ~aclk;

    csr_unit #(.MHART_ID(HART_ID)) csr_unit_inst (.*);

    csr_checker #(.MHART_ID(HART_ID)) chk (.*);

    function automatic logic [INST_W-1:0] encode(input csr_op_e op, input logic [4:0] rd,
                                                 input logic [4:0] rs1,
                                                 input logic [CSR_ADDR_W-1:0] csr);
        return {csr, rs1, op, rd, 7'b1110011};     // SYSTEM opcode
    endfunction

    function automatic trap_upd_t rand_trap();
        return {1'($urandom % 2), 32'($urandom), 1'($urandom % 2), 32'($urandom),
                1'($urandom % 2), 32'($urandom), 1'($urandom % 2), 32'($urandom)};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #DRV_DLY;
        end
    endtask

    task automatic wait_ready();
        while (!ready) begin
            wait_cycles(1);
        end
    endtask

    // Returns just after acceptance, or after the trap pulse
    task automatic issue(input logic [INST_W-1:0] word, input logic [XLEN-1:0] rs1v,
                         input trap_upd_t trap, input int trap_cyc);
        valid   = 1'b1;
        instbus = word;
        rs1_val = rs1v;
        wait_ready();
        wait_cycles(1);         // Acceptance edge
        valid = 1'b0;
        if (trap_cyc >= 0) begin
            wait_cycles(trap_cyc);
            trap_upd = trap;
            wait_cycles(1);
            trap_upd = '0;
        end
    endtask

    task automatic run(input csr_op_e op, input logic [CSR_ADDR_W-1:0] csr,
                       input logic [4:0] rs1, input logic [XLEN-1:0] rs1v);
        issue(encode(op, 5'($urandom), rs1, csr), rs1v, '0, -1);
    endtask

    task automatic rand_inst();
        int                    pick;
        int                    trap_cyc;
        logic [CSR_ADDR_W-1:0] csr;
        logic [4:0]            rs1;
        pick     = $urandom % 12;
        csr      = (pick < 10) ? addr_list[pick] : (12'hB00 | 12'($urandom % 256));
        rs1      = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
        trap_cyc = ($urandom % 4 == 0) ? int'($urandom % 3) : -1;
        if ($urandom % 8 == 0) begin
            eirq = ~eirq;
        end
        issue(encode(op_list[$urandom % 6], 5'($urandom), rs1, csr), $urandom, rand_trap(),
              trap_cyc);
    endtask

    // Watchdog
    initial begin
        #((N_INST * 3 + RST_CYC + 1000) * PERIOD);
        $display("Timeout: the DUT did not finish all instructions in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        trap_upd_t            t;
        logic [CSR_ADDR_W-1:0] warl_list [5];
        void'($urandom(seed));
        aclk     = 1'b0;
        aresetn  = 1'b0;
        eirq     = 1'b0;
        valid    = 1'b0;
        instbus  = '0;
        rs1_val  = '0;
        trap_upd = '0;
        warl_list = '{CSR_MSTATUS, CSR_MEPC, CSR_MISA, CSR_MHARTID, 12'h7C0};
        repeat (RST_CYC) @(posedge aclk);
        #DRV_DLY;
        aresetn = 1'b1;

        foreach (addr_list[i]) run(OP_CSRRS, addr_list[i], 5'd0, $urandom);    // Reads only
        chk.end_test("reset_values");

        run(OP_CSRRW, CSR_MSCRATCH, 5'd5, 32'hA5A5_5A5A);
        run(OP_CSRRW, CSR_MSCRATCH, 5'd6, 32'h1234_5678);
        run(OP_CSRRWI, CSR_MTVEC, 5'h1F, '0);
        run(OP_CSRRW, CSR_MTVEC, 5'd7, 32'h8000_0100);
        run(OP_CSRRS, CSR_MTVEC, 5'd0, '0);
        chk.end_test("read_write");

        run(OP_CSRRS, CSR_MSCRATCH, 5'd3, 32'h0000_00F0);
        run(OP_CSRRC, CSR_MSCRATCH, 5'd4, 32'h0000_0030);
        run(OP_CSRRSI, CSR_MSCRATCH, 5'h0F, '0);
        run(OP_CSRRCI, CSR_MSCRATCH, 5'h03, '0);
        run(OP_CSRRS, CSR_MSCRATCH, 5'd0, '1);     // x0 leaves it alone
        run(OP_CSRRC, CSR_MSCRATCH, 5'd0, '1);
        run(OP_CSRRCI, CSR_MSCRATCH, 5'd0, '0);
        run(OP_CSRRSI, CSR_MSCRATCH, 5'd0, '0);
        chk.end_test("set_clear");

        foreach (warl_list[i]) begin
            run(OP_CSRRW, warl_list[i], 5'd1, '1);
            run(OP_CSRRS, warl_list[i], 5'd0, '0);
        end
        chk.end_test("warl_rules");

        // Trap lands on the same edge as the CSR write
        t = '0;
        t.mepc    = {1'b1, 32'h0000_2002};
        t.mstatus = {1'b1, 32'hFFFF_FFFF};
        issue(encode(OP_CSRRW, 5'd1, 5'd2, CSR_MEPC), 32'h0000_1000, t, 1);
        issue(encode(OP_CSRRW, 5'd1, 5'd2, CSR_MSTATUS), 32'h0, t, 1);
        t = '0;
        t.mcause = {1'b1, 32'h8000_000B};
        t.mtval  = {1'b1, 32'hDEAD_BEEF};
        issue(encode(OP_CSRRS, 5'd1, 5'd0, CSR_MSCRATCH), '0, t, 0);
        foreach (addr_list[i]) run(OP_CSRRS, addr_list[i], 5'd0, '0);
        chk.end_test("trap_update");

        run(OP_CSRRWI, CSR_MSTATUS, 5'h08, '0);     // MIE only
        eirq = 1'b1;
        wait_cycles(6);
        run(OP_CSRRS, CSR_MIP, 5'd0, '0);           // mie still clear
        run(OP_CSRRS, CSR_MIE, 5'd2, 32'h0000_0800);
        wait_cycles(6);
        run(OP_CSRRS, CSR_MIP, 5'd0, '0);
        eirq = 1'b0;
        wait_cycles(4);
        run(OP_CSRRW, CSR_MIP, 5'd0, '0);
        run(OP_CSRRCI, CSR_MSTATUS, 5'h08, '0);
        eirq = 1'b1;
        wait_cycles(6);
        run(OP_CSRRS, CSR_MIP, 5'd0, '0);           // Global enable off
        eirq = 1'b0;
        chk.end_test("ext_interrupt");

        repeat (N_RAND) rand_inst();
        wait_ready();
        chk.end_test("random");

        chk.summary();
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
common/csr_pkg.sv
csr/csr_exec.sv
csr/csr_regfile.sv
logic/csr_unit.sv
dv/csr_checker.sv
dv/tb_csr_unit.sv
